/* Bender.yml */
package:
  name: qla_io

sources:
  - logic/qla_pkg.sv
  - logic/reg_bus_if.sv
  - logic/host_bus_arbiter.sv
  - logic/cur_cmd_regs.sv
  - logic/dac_serializer.sv
  - logic/safety_check.sv
  - logic/board_status_reg.sv
  - logic/qla_io_top.sv
  - target: simulation
    files:
      - testbench/tb_qla_io.sv

/* logic/board_status_reg.sv */
`timescale 1ns/1ps

module board_status_reg (
    input  logic               sysclk,
    input  logic               rst_n,
    reg_bus_if.target          bus,
    input  logic [3:0]         wenid,          // rotary switch, inverted id
    input  logic [4:1]         amp_disable,
    output qla_pkg::reg_data_t status_word,
    output logic [4:1]         clear_disable
);

    logic       status_wr;       // quadlet write to chan 0 status
    logic       pwr_enable;      // level kept for the host
    logic       pwr_enable_cmd;  // pulse, clears every axis
    logic [4:1] amp_enable_cmd;  // pulse per axis

    assign status_wr = bus.wen &&
                       (bus.waddr[15:12] == qla_pkg::ADDR_MAIN) &&
                       (bus.waddr[7:4] == 4'd0) &&
                       (bus.waddr[3:0] == qla_pkg::OFF_STATUS);

    // --------------------------------------------------
    // enable commands
    // --------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            pwr_enable     <= 1'b0;
            pwr_enable_cmd <= 1'b0;
            amp_enable_cmd <= '0;
        end else begin
            pwr_enable_cmd <= status_wr && bus.wdata[qla_pkg::STATUS_PWR_BIT];
            amp_enable_cmd <= status_wr ? bus.wdata[3:0] : 4'b0000;  // bit 0 is axis 1
            if (status_wr)
                pwr_enable <= bus.wdata[qla_pkg::STATUS_PWR_BIT];
        end
    end

    assign clear_disable = {4{pwr_enable_cmd}} | amp_enable_cmd;

    // status quadlet
    always_comb begin
        status_word                                   = '0;
        status_word[qla_pkg::STATUS_BOARD_LSB +: 4]   = ~wenid;  // board id
        status_word[qla_pkg::STATUS_PWR_BIT]          = pwr_enable;
        status_word[3:0]                              = amp_disable;
    end

endmodule

/* logic/cur_cmd_regs.sv */
`timescale 1ns/1ps

module cur_cmd_regs (
    input  logic                sysclk,
    input  logic                rst_n,
    reg_bus_if.target           bus,
    input  logic                dac_busy,    // frame in progress
    output qla_pkg::cur_array_t cur_cmd,
    output logic                cmd_update   // one-cycle DAC load
);

    qla_pkg::chan_t wr_chan;
    logic           dac_hit;     // write targets an axis DAC register
    logic           cmd_req;     // block ended, frame owed
    logic           req_go;

    assign wr_chan = bus.waddr[7:4];

    // chan 0 is the board, not an axis
    assign dac_hit = (bus.waddr[15:12] == qla_pkg::ADDR_MAIN) &&
                     (wr_chan != '0) && (wr_chan <= qla_pkg::NUM_CHANNELS) &&
                     (bus.waddr[3:0] == qla_pkg::OFF_DAC_CTRL);

    // hold off while the previous load is still reaching the DAC
    assign req_go = cmd_req && !dac_busy && !cmd_update;

    // --------------------------------------------------
    // command registers and DAC request
    // --------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd    <= {qla_pkg::NUM_CHANNELS{qla_pkg::CUR_ZERO}};  // all axes at zero
            cmd_req    <= 1'b0;
            cmd_update <= 1'b0;
        end else begin
            if (dac_hit && bus.wen)
                cur_cmd[wr_chan] <= bus.wdata[15:0];
            if (dac_hit && bus.blk_wen)
                cmd_req <= 1'b1;     // a new block end outranks the release
            else if (req_go)
                cmd_req <= 1'b0;
            cmd_update <= req_go;
        end
    end

    // busy from the serializer must block every load pulse
    a_no_update_busy: assert property (@(posedge sysclk) disable iff (!rst_n)
        cmd_update |-> !dac_busy);

endmodule

/* logic/dac_serializer.sv */
`timescale 1ns/1ps

module dac_serializer #(
    parameter int DAC_SCLK_DIV = 2  // sysclk cycles per half sclk
) (
    input  logic                sysclk,
    input  logic                rst_n,
    input  logic                cmd_update,
    input  qla_pkg::cur_array_t cur_cmd,
    output logic                busy,
    output logic                sclk,
    output logic                mosi,
    output logic                csel   // active low
);

    localparam int FRAME = qla_pkg::DAC_FRAME_BITS;
    localparam int BIT_W = $clog2(FRAME);
    localparam int DIV_W = (DAC_SCLK_DIV > 1) ? $clog2(DAC_SCLK_DIV) : 1;

    typedef enum logic [1:0] {DAC_IDLE, DAC_SHIFT, DAC_END} dac_state_e;

    dac_state_e       state;
    logic [DIV_W-1:0] div_cnt;   // half period timer
    logic [BIT_W-1:0] bit_cnt;   // bits already sent
    logic [FRAME-1:0] shreg;     // axis 1 msb on top
    logic             half_end;

    assign half_end = (state == DAC_SHIFT) && (div_cnt == DIV_W'(DAC_SCLK_DIV - 1));
    assign mosi     = shreg[FRAME-1] & ~csel;  // quiet while deselected

    // --------------------------------------------------
    // frame FSM
    // --------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state   <= DAC_IDLE;
            busy    <= 1'b0;
            csel    <= 1'b1;
            sclk    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                DAC_IDLE: if (cmd_update) begin
                    state   <= DAC_SHIFT;
                    busy    <= 1'b1;
                    csel    <= 1'b0;   // first bit already on mosi
                    div_cnt <= '0;
                    bit_cnt <= '0;
                end
                DAC_SHIFT: begin
                    div_cnt <= half_end ? '0 : div_cnt + 1'b1;
                    if (half_end) begin
                        sclk <= ~sclk;
                        if (sclk) begin             // falling edge, bit done
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_W'(FRAME - 1))
                                state <= DAC_END;
                        end
                    end
                end
                default: begin                       // DAC_END, release chip select
                    state <= DAC_IDLE;
                    busy  <= 1'b0;
                    csel  <= 1'b1;
                end
            endcase
        end
    end

    // payload, shifted as sclk falls
    always_ff @(posedge sysclk) begin
        if (state == DAC_IDLE && cmd_update)
            shreg <= cur_cmd;
        else if (half_end && sclk)
            shreg <= {shreg[FRAME-2:0], 1'b0};
    end

    // idle: chip select released and sclk parked low after the last falling edge
    a_csel_idle: assert property (@(posedge sysclk) disable iff (!rst_n)
        !busy |-> csel && !sclk);

endmodule

/* logic/host_bus_arbiter.sv */
`timescale 1ns/1ps

module host_bus_arbiter (
    input  logic               sysclk,
    input  logic               rst_n,
    // firewire host
    input  logic               fw_reg_wen,
    input  logic               fw_blk_wen,
    input  qla_pkg::reg_addr_t fw_reg_waddr,
    input  qla_pkg::reg_addr_t fw_reg_raddr,
    input  qla_pkg::reg_data_t fw_reg_wdata,
    // ethernet host
    input  logic               eth_reg_wen,
    input  logic               eth_blk_wen,
    input  qla_pkg::reg_addr_t eth_reg_waddr,
    input  qla_pkg::reg_addr_t eth_reg_raddr,
    input  qla_pkg::reg_data_t eth_reg_wdata,
    input  logic               eth_write_en,  // eth owns write bus
    input  logic               eth_read_en,   // eth owns read address
    reg_bus_if.host            bus,
    // read sources
    input  qla_pkg::cur_array_t cur_cmd,
    input  qla_pkg::cur_array_t cur_fb,
    input  qla_pkg::reg_data_t  status_word,  // board id at STATUS_BOARD_LSB, pwr at STATUS_PWR_BIT
    output qla_pkg::reg_data_t  reg_rdata
);

    qla_pkg::reg_addr_t raddr;     // selected read address
    qla_pkg::chan_t     rd_chan;
    logic [3:0]         rd_off;
    qla_pkg::reg_data_t rd_next;   // decoded quadlet, registered below

    // --------------------------------------------------
    // write bus owner, ethernet wins
    // --------------------------------------------------
    always_comb begin
        if (eth_write_en) begin
            bus.wen     = eth_reg_wen;
            bus.blk_wen = eth_blk_wen;
            bus.waddr   = eth_reg_waddr;
            bus.wdata   = eth_reg_wdata;
        end else begin
            bus.wen     = fw_reg_wen;
            bus.blk_wen = fw_blk_wen;
            bus.waddr   = fw_reg_waddr;
            bus.wdata   = fw_reg_wdata;
        end
    end

    // --------------------------------------------------
    // read decode
    // --------------------------------------------------
    assign raddr   = eth_read_en ? eth_reg_raddr : fw_reg_raddr;
    assign rd_chan = raddr[7:4];
    assign rd_off  = raddr[3:0];

    always_comb begin
        rd_next = '0;  // unmapped reads as zero
        if (raddr[15:12] == qla_pkg::ADDR_MAIN) begin
            if (rd_chan == '0) begin
                if (rd_off == qla_pkg::OFF_STATUS)
                    rd_next = status_word;
            end else if (rd_chan <= qla_pkg::NUM_CHANNELS) begin
                case (rd_off)
                    qla_pkg::OFF_ADC_DATA: rd_next = {16'h0000, cur_fb[rd_chan]};
                    qla_pkg::OFF_DAC_CTRL: rd_next = {16'h0000, cur_cmd[rd_chan]};
                    default:               rd_next = '0;
                endcase
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n)
            reg_rdata <= '0;
        else
            reg_rdata <= rd_next;  // one cycle behind the address
    end

    // whichever host drives, a strobe always comes with a known address
    a_strobe_addr_known: assert property (@(posedge sysclk) disable iff (!rst_n)
        (bus.wen || bus.blk_wen) |-> !$isunknown(bus.waddr));

endmodule

/* logic/qla_io_top.sv */
`timescale 1ns/1ps

module qla_io_top #(
    parameter int SAFETY_LIMIT_CYCLES = 8,
    parameter int DAC_SCLK_DIV        = 2
) (
    input  logic                sysclk,
    input  logic                rst_n,
    input  logic [3:0]          wenid,
    input  qla_pkg::cur_array_t cur_fb,         // measured currents
    // firewire host
    input  logic                fw_reg_wen,
    input  logic                fw_blk_wen,
    input  qla_pkg::reg_addr_t  fw_reg_waddr,
    input  qla_pkg::reg_addr_t  fw_reg_raddr,
    input  qla_pkg::reg_data_t  fw_reg_wdata,
    // ethernet host
    input  logic                eth_reg_wen,
    input  logic                eth_blk_wen,
    input  qla_pkg::reg_addr_t  eth_reg_waddr,
    input  qla_pkg::reg_addr_t  eth_reg_raddr,
    input  qla_pkg::reg_data_t  eth_reg_wdata,
    input  logic                eth_write_en,
    input  logic                eth_read_en,
    output qla_pkg::reg_data_t  reg_rdata,
    // quad DAC
    output logic                dac_sclk,
    output logic                dac_mosi,
    output logic                dac_csel,
    output logic [4:1]          amp_disable
);

    qla_pkg::cur_array_t cur_cmd;
    qla_pkg::reg_data_t  status_word;
    logic                cmd_update;
    logic                dac_busy;
    logic [4:1]          clear_disable;

    reg_bus_if bus ();  // shared write bus

    host_bus_arbiter i_arbiter (
        .sysclk, .rst_n,
        .fw_reg_wen, .fw_blk_wen, .fw_reg_waddr, .fw_reg_raddr, .fw_reg_wdata,
        .eth_reg_wen, .eth_blk_wen, .eth_reg_waddr, .eth_reg_raddr, .eth_reg_wdata,
        .eth_write_en, .eth_read_en,
        .bus         (bus.host),
        .cur_cmd, .cur_fb, .status_word, .reg_rdata
    );

    cur_cmd_regs i_cur_cmd (
        .sysclk, .rst_n, .bus(bus.target), .dac_busy, .cur_cmd, .cmd_update
    );

    dac_serializer #(.DAC_SCLK_DIV(DAC_SCLK_DIV)) i_dac (
        .sysclk, .rst_n, .cmd_update, .cur_cmd,
        .busy(dac_busy), .sclk(dac_sclk), .mosi(dac_mosi), .csel(dac_csel)
    );

    board_status_reg i_status (
        .sysclk, .rst_n, .bus(bus.target), .wenid, .amp_disable, .status_word, .clear_disable
    );

    // --------------------------------------------------
    // one overcurrent check per axis
    // --------------------------------------------------
    for (genvar i = 1; i <= qla_pkg::NUM_CHANNELS; i++) begin : g_safety
        safety_check #(.SAFETY_LIMIT_CYCLES(SAFETY_LIMIT_CYCLES)) i_safety (
            .sysclk, .rst_n,
            .cur_in        (cur_fb[i]),
            .cmd_in        (cur_cmd[i]),
            .clear_disable (clear_disable[i]),
            .amp_disable   (amp_disable[i])
        );
    end

endmodule

/* logic/qla_pkg.sv */
package qla_pkg;

    // --------------------------------------------------
    // board geometry and widths
    // --------------------------------------------------
    localparam int NUM_CHANNELS   = 4;                  // axes 1..4, channel 0 is the board
    localparam int DAC_FRAME_BITS = NUM_CHANNELS * 16;  // one quad DAC frame

    typedef logic [15:0] reg_addr_t;  // [15:12] space, [7:4] channel, [3:0] offset
    typedef logic [31:0] reg_data_t;  // one quadlet
    typedef logic [15:0] cur_t;       // offset binary current
    typedef logic [3:0]  chan_t;

    // axis 1 sits in the top slice, so a flat copy is already frame order
    typedef cur_t [1:NUM_CHANNELS] cur_array_t;

    localparam cur_t CUR_ZERO = 16'h8000;  // zero current

    // --------------------------------------------------
    // register map
    // --------------------------------------------------
    typedef enum logic [3:0] {
        ADDR_MAIN = 4'h0  // board registers, the only space still decoded
    } addr_space_e;

    typedef enum logic [3:0] {
        OFF_ADC_DATA = 4'h0,  // chan 1..4, measured current
        OFF_DAC_CTRL = 4'h1   // chan 1..4, commanded current
    } reg_offset_e;

    // chan 0 status shares offset 0 with the adc data of the axes
    localparam reg_offset_e OFF_STATUS = OFF_ADC_DATA;

    // status word fields
    localparam int STATUS_PWR_BIT   = 4;   // power enable level
    localparam int STATUS_BOARD_LSB = 24;  // 4-bit board id

endpackage

/* logic/reg_bus_if.sv */
`timescale 1ns/1ps

// internal register write bus, driven by whichever host owns it
interface reg_bus_if;

    qla_pkg::reg_addr_t waddr;    // quadlet address
    qla_pkg::reg_data_t wdata;    // quadlet data
    logic               wen;      // one quadlet per high cycle
    logic               blk_wen;  // one-cycle pulse at end of block write

    // arbiter side
    modport host (
        output waddr, wdata, wen, blk_wen
    );

    // register blocks
    modport target (
        input waddr, wdata, wen, blk_wen
    );

endinterface

/* logic/safety_check.sv */
`timescale 1ns/1ps

module safety_check #(
    parameter int SAFETY_LIMIT_CYCLES = 8  // consecutive overcurrent cycles to trip
) (
    input  logic          sysclk,
    input  logic          rst_n,
    input  qla_pkg::cur_t cur_in,         // measured
    input  qla_pkg::cur_t cmd_in,         // commanded
    input  logic          clear_disable,
    output logic          amp_disable
);

    localparam int CNT_W = $clog2(SAFETY_LIMIT_CYCLES + 1);

    logic [15:0]      fb_mag;    // |cur_in - zero|
    logic [15:0]      cmd_mag;   // |cmd_in - zero|
    logic             over;
    logic [CNT_W-1:0] over_cnt;  // saturates at the limit

    // distance from the offset binary midpoint
    assign fb_mag  = (cur_in >= qla_pkg::CUR_ZERO) ? cur_in - qla_pkg::CUR_ZERO
                                                   : qla_pkg::CUR_ZERO - cur_in;
    assign cmd_mag = (cmd_in >= qla_pkg::CUR_ZERO) ? cmd_in - qla_pkg::CUR_ZERO
                                                   : qla_pkg::CUR_ZERO - cmd_in;

    // feedback more than twice the command
    assign over = {1'b0, fb_mag} > {cmd_mag, 1'b0};

    // --------------------------------------------------
    // trip counter and disable latch
    // --------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            over_cnt    <= '0;
            amp_disable <= 1'b0;
        end else begin
            if (!over)
                over_cnt <= '0;   // streak broken
            else if (over_cnt < CNT_W'(SAFETY_LIMIT_CYCLES))
                over_cnt <= over_cnt + 1'b1;

            if (clear_disable)
                amp_disable <= 1'b0;
            else if (over && over_cnt >= CNT_W'(SAFETY_LIMIT_CYCLES - 1))
                amp_disable <= 1'b1;  // latched until host clears
        end
    end

endmodule

/* sources.f */
logic/qla_pkg.sv
logic/reg_bus_if.sv
logic/host_bus_arbiter.sv
logic/cur_cmd_regs.sv
logic/dac_serializer.sv
logic/safety_check.sv
logic/board_status_reg.sv
logic/qla_io_top.sv
testbench/tb_qla_io.sv

/* testbench/tb_qla_io.sv */
`timescale 1ns/1ps

module tb_qla_io;

    localparam int SAFETY_LIMIT   = 8;
    localparam int SCLK_DIV       = 2;
    localparam int FRAME_CYCLES   = 64 * 2 * SCLK_DIV + 1;      // one DAC frame
    localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + 4715;   // frames plus register traffic

    localparam qla_pkg::reg_addr_t STATUS_ADDR = 16'h0000;    // chan 0, offset 0

    logic                sysclk;
    logic                rst_n;
    logic [3:0]          wenid;
    qla_pkg::cur_array_t cur_fb;
    logic                fw_reg_wen;
    logic                fw_blk_wen;
    qla_pkg::reg_addr_t  fw_reg_waddr;
    qla_pkg::reg_addr_t  fw_reg_raddr;
    qla_pkg::reg_data_t  fw_reg_wdata;
    logic                eth_reg_wen;
    logic                eth_blk_wen;
    qla_pkg::reg_addr_t  eth_reg_waddr;
    qla_pkg::reg_addr_t  eth_reg_raddr;
    qla_pkg::reg_data_t  eth_reg_wdata;
    logic                eth_write_en;
    logic                eth_read_en;
    qla_pkg::reg_data_t  reg_rdata;
    logic                dac_sclk;
    logic                dac_mosi;
    logic                dac_csel;
    logic [4:1]          amp_disable;

    qla_pkg::cur_array_t cmd_model;      // expected axis commands
    logic [31:0]         rng;
    int                  cycle_cnt;
    int                  chk_cnt;
    int                  err_cnt;
    int                  test_cnt;
    int                  test_err_base;  // errors before the running test
    logic [63:0]         frames [$];     // captured DAC frames
    logic [63:0]         cap_shift;
    int                  cap_bits;

    qla_io_top #(
        .SAFETY_LIMIT_CYCLES (SAFETY_LIMIT),
        .DAC_SCLK_DIV        (SCLK_DIV)
    ) i_dut (.*);

    always #2 sysclk = ~sysclk;  // 4 ns period

    // --------------------------------------------------
    // timeout and DAC capture
    // --------------------------------------------------
    always @(posedge sysclk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // mosi is stable on the rising sclk edge
    always @(posedge dac_sclk) begin
        if (dac_csel === 1'b0) begin
            cap_shift = {cap_shift[62:0], dac_mosi};  // msb first
            cap_bits++;
            if (cap_bits == 64) begin
                frames.push_back(cap_shift);
                cap_bits = 0;
            end
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // main space, chan in [7:4], offset 1
    function automatic qla_pkg::reg_addr_t dac_addr(input int chan);
        return {4'h0, 4'h0, 4'(chan), 4'h1};
    endfunction

    task automatic next_cycle();
        @(posedge sysclk);
        #0.5;  // drive and sample away from the edge
    endtask

    task automatic fw_write(input qla_pkg::reg_addr_t addr, input qla_pkg::reg_data_t data);
        fw_reg_wen   = 1'b1;
        fw_reg_waddr = addr;
        fw_reg_wdata = data;
        next_cycle();
        fw_reg_wen   = 1'b0;
    endtask

    task automatic eth_write(input qla_pkg::reg_addr_t addr, input qla_pkg::reg_data_t data);
        eth_write_en  = 1'b1;  // eth takes the bus
        eth_reg_wen   = 1'b1;
        eth_reg_waddr = addr;
        eth_reg_wdata = data;
        next_cycle();
        eth_reg_wen   = 1'b0;
        eth_write_en  = 1'b0;
    endtask

    task automatic fw_block_end(input qla_pkg::reg_addr_t addr);
        fw_blk_wen   = 1'b1;
        fw_reg_waddr = addr;
        next_cycle();
        fw_blk_wen   = 1'b0;
    endtask

    // registered read, data valid one edge after the address
    task automatic read_reg(input logic use_eth, input qla_pkg::reg_addr_t addr,
                            output qla_pkg::reg_data_t data);
        if (use_eth) begin
            eth_read_en   = 1'b1;
            eth_reg_raddr = addr;
        end else begin
            fw_reg_raddr = addr;
        end
        next_cycle();
        data        = reg_rdata;
        eth_read_en = 1'b0;
    endtask

    task automatic wait_csel(input logic level);
        while (dac_csel !== level)
            next_cycle();
    endtask

    task automatic check_data(input string name, input qla_pkg::reg_data_t got,
                              input qla_pkg::reg_data_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_cur(input string name, input qla_pkg::cur_t got,
                             input qla_pkg::cur_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_cmds();
        qla_pkg::reg_data_t rd;
        for (int i = 1; i <= qla_pkg::NUM_CHANNELS; i++) begin
            read_reg(1'b0, dac_addr(i), rd);
            check_data($sformatf("reg_rdata chan %0d dac", i), rd, {16'h0000, cmd_model[i]});
        end
    endtask

    // axis 1 in bits 63:48
    task automatic check_frame(input logic [63:0] f, input qla_pkg::cur_array_t exp);
        for (int i = 1; i <= qla_pkg::NUM_CHANNELS; i++)
            check_cur($sformatf("dac frame axis %0d", i), f[64 - 16 * i +: 16], exp[i]);
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        $display("test %0d %s done, %0d errors", test_cnt, name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset();
        qla_pkg::reg_data_t rd;
        qla_pkg::reg_data_t exp;
        exp        = '0;
        exp[27:24] = ~wenid;  // board id only
        read_reg(1'b0, STATUS_ADDR, rd);
        check_data("reg_rdata status", rd, exp);
        check_data("amp_disable", 32'(amp_disable), 32'h0);
        check_bit("dac_csel", dac_csel, 1'b1);
        check_cmds();         // all axes at zero current
        end_test("reset state");
    endtask

    task automatic test_fw_cmds();
        qla_pkg::reg_data_t rd;
        logic               seen_low;
        for (int i = 1; i <= qla_pkg::NUM_CHANNELS; i++) begin
            rng          = xorshift(rng);
            cmd_model[i] = rng[15:0];
            fw_write(dac_addr(i), rng);  // upper half not stored
        end
        check_cmds();
        fw_write(dac_addr(0), 32'h0000_1234);  // chan 0 is no axis
        check_cmds();
        read_reg(1'b0, dac_addr(0), rd);
        check_data("reg_rdata chan 0 dac", rd, 32'h0);
        seen_low = 1'b0;
        repeat (200) begin
            next_cycle();
            if (dac_csel !== 1'b1)
                seen_low = 1'b1;
        end
        check_bit("dac_csel held high", ~seen_low, 1'b1);
        end_test("firewire commands");
    endtask

    task automatic test_arbitration();
        qla_pkg::reg_data_t rd;
        qla_pkg::cur_t      fw_val;
        qla_pkg::cur_t      eth_val;
        rng     = xorshift(rng);
        fw_val  = rng[15:0];
        eth_val = rng[31:16];
        fw_reg_wen   = 1'b1;      // collides with the eth write
        fw_reg_waddr = dac_addr(1);
        fw_reg_wdata = {16'h0000, fw_val};
        eth_write(dac_addr(2), {16'h0000, eth_val});
        fw_reg_wen   = 1'b0;
        cmd_model[2] = eth_val;   // chan 1 keeps its value
        fw_reg_raddr = dac_addr(1);
        read_reg(1'b1, dac_addr(2), rd);
        check_data("reg_rdata eth read", rd, {16'h0000, eth_val});
        check_cmds();
        end_test("host arbitration");
    endtask

    task automatic test_dac_frames();
        qla_pkg::cur_array_t first;
        logic                seen_low;
        for (int i = 1; i <= qla_pkg::NUM_CHANNELS; i++) begin
            rng          = xorshift(rng);
            cmd_model[i] = rng[15:0];
            fw_write(dac_addr(i), {16'h0000, rng[15:0]});
        end
        first = cmd_model;
        frames.delete();
        fw_block_end(dac_addr(4));
        wait_csel(1'b0);
        // new axis 3 value and a second request, both mid frame
        rng          = xorshift(rng);
        cmd_model[3] = rng[15:0];
        fw_write(dac_addr(3), {16'h0000, rng[15:0]});
        fw_block_end(dac_addr(3));
        wait_csel(1'b1);
        check_data("dac frame count", 32'(frames.size()), 32'd1);
        if (frames.size() >= 1)
            check_frame(frames[0], first);
        wait_csel(1'b0);
        wait_csel(1'b1);
        check_data("dac frame count", 32'(frames.size()), 32'd2);
        if (frames.size() >= 2)
            check_frame(frames[1], cmd_model);
        seen_low = 1'b0;
        repeat (100) begin  // no third frame
            next_cycle();
            if (dac_csel !== 1'b1)
                seen_low = 1'b1;
        end
        check_bit("dac_csel idle after frames", ~seen_low, 1'b1);
        end_test("dac frames");
    endtask

    task automatic test_safety();
        qla_pkg::reg_data_t rd;
        qla_pkg::reg_data_t exp;
        cmd_model[2] = 16'h8100;
        fw_write(dac_addr(2), 32'h0000_8100);
        cur_fb[2] = 16'h8180;    // under twice the command
        repeat (30) next_cycle();
        check_data("amp_disable", 32'(amp_disable), 32'h0);
        cur_fb[2] = 16'h8300;    // over the limit
        repeat (20) next_cycle();
        check_data("amp_disable", 32'(amp_disable), 32'h2);  // axis 2 only
        exp        = '0;
        exp[27:24] = ~wenid;
        exp[1]     = 1'b1;       // axis 2 disable
        read_reg(1'b0, STATUS_ADDR, rd);
        check_data("reg_rdata status", rd, exp);
        cur_fb[2] = 16'h8000;
        next_cycle();
        fw_write(STATUS_ADDR, 32'h0000_0002);  // amp enable for axis 2
        repeat (2) next_cycle();
        check_data("amp_disable", 32'(amp_disable), 32'h0);
        exp[1] = 1'b0;
        read_reg(1'b0, STATUS_ADDR, rd);
        check_data("reg_rdata status", rd, exp);
        end_test("safety disable");
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        sysclk        = 1'b0;
        rst_n         = 1'b0;
        wenid         = 4'b0101;            // board id 4'ha
        cur_fb        = {4{16'h8000}};
        fw_reg_wen    = 1'b0;
        fw_blk_wen    = 1'b0;
        fw_reg_waddr  = '0;
        fw_reg_raddr  = '0;
        fw_reg_wdata  = '0;
        eth_reg_wen   = 1'b0;
        eth_blk_wen   = 1'b0;
        eth_reg_waddr = '0;
        eth_reg_raddr = '0;
        eth_reg_wdata = '0;
        eth_write_en  = 1'b0;
        eth_read_en   = 1'b0;
        cmd_model     = {4{16'h8000}};      // reset value of every axis
        rng           = 32'hf719_1a94;
        cycle_cnt     = 0;
        chk_cnt       = 0;
        err_cnt       = 0;
        test_cnt      = 0;
        test_err_base = 0;
        cap_bits      = 0;
        repeat (5) @(posedge sysclk);
        #0.5;
        rst_n = 1'b1;

        test_reset();
        test_fw_cmds();
        test_arbitration();
        test_dac_frames();
        test_safety();

        $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
